//--- include/edge_consts.svh
/* sizing, register map and latency for the edge pipeline
   line width sets the line buffer depth; shorter frames are fine */
`ifndef EDGE_CONSTS_SVH
`define EDGE_CONSTS_SVH

`define EDGE_LINE_W     320
`define EDGE_IMG_H      240

`define EDGE_REG_CTRL   2'd0    // bit 0 enable
`define EDGE_REG_THRESH 2'd1
`define EDGE_REG_COUNT  2'd2    // write clears

`define EDGE_WIN_LAT    1
`define EDGE_GAUSS_LAT  2
`define EDGE_SOBEL_LAT  2
`define EDGE_TOTAL_LAT  6       // win + gauss + win + sobel

`endif

//--- hw/edge_pkg.sv
/* shared vector types for the edge pipeline
   coordinate widths cover up to 512 columns and 256 rows */
package edge_pkg;

    // one grayscale sample
    typedef logic [7:0] pixel_t;

    // raster position
    typedef logic [8:0] coord_x_t;
    typedef logic [7:0] coord_y_t;

    // weighted row sum or one absolute gradient, 4*255 at most
    typedef logic [10:0] grad_t;

    // |gx| + |gy| before saturation, also wide enough for 16*255
    typedef logic [11:0] mag_t;

    // register word address on the wishbone side
    typedef logic [1:0] wb_addr_t;

endpackage

//--- hw/pixel_stream_if.sv
/* one pixel per cycle with its raster position
   no ready signal, a stage must take every valid beat */
interface pixel_stream_if;

    logic                valid;
    edge_pkg::pixel_t    pixel;
    edge_pkg::coord_x_t  x;
    edge_pkg::coord_y_t  y;

    modport src (
        output valid,
        output pixel,
        output x,
        output y
    );

    modport sink (
        input valid,
        input pixel,
        input x,
        input y
    );

endinterface

//--- hw/line_window_3x3.sv
/* 3x3 window ending at the newest pixel, zero outside the image
   needs a pixel with x = 0 at each line start and x = 0, y = 0 at frame start
   taps are row major, oldest row first, column x-2 first */
`include "edge_consts.svh"

module line_window_3x3 (
    input  logic                clk,
    input  logic                rst,
    pixel_stream_if.sink        s,
    output edge_pkg::pixel_t    taps [9],
    output logic                win_valid,
    output edge_pkg::coord_x_t  win_x,
    output edge_pkg::coord_y_t  win_y
);

    // two lines: one holds row y-2 and is overwritten, the other holds y-1
    edge_pkg::pixel_t line_buf [2][`EDGE_LINE_W];

    logic             wr_sel;       // buffer written by the current line
    logic             cur_sel;
    logic             line_start;
    edge_pkg::pixel_t col_in [3];   // incoming column, oldest row first

    assign line_start = (s.x == '0);

    // ping-pong select, forced to 0 at frame start
    always_comb begin
        if (!line_start) begin
            cur_sel = wr_sel;
        end else if (s.y == '0) begin
            cur_sel = 1'b0;
        end else begin
            cur_sel = ~wr_sel;
        end
    end

    // older rows at this column, read ahead of the write, padded on top
    always_comb begin
        col_in[0] = (s.y < 2)   ? '0 : line_buf[cur_sel][s.x];    // row y-2
        col_in[1] = (s.y == '0) ? '0 : line_buf[~cur_sel][s.x];   // row y-1
        col_in[2] = s.pixel;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_sel    <= 1'b0;
            win_valid <= 1'b0;
        end else begin
            win_valid <= s.valid;
            if (s.valid) begin
                wr_sel <= cur_sel;
            end
        end
    end

    // three shift rows; left columns drop to zero at line start
    always_ff @(posedge clk) begin
        if (s.valid) begin
            line_buf[cur_sel][s.x] <= s.pixel;
            win_x <= s.x;
            win_y <= s.y;
            for (int r = 0; r < 3; r++) begin
                taps[3*r]   <= line_start ? '0 : taps[3*r+1];   // x-2
                taps[3*r+1] <= line_start ? '0 : taps[3*r+2];   // x-1
                taps[3*r+2] <= col_in[r];                       // x
            end
        end
    end

endmodule

//--- hw/gauss_3x3.sv
/* 1-2-1 by 1-2-1 gaussian, divide by 16 with truncation, 2 cycles
   coordinates pass unchanged, output belongs to the window centre */
module gauss_3x3 (
    input  logic                clk,
    input  logic                rst,
    input  edge_pkg::pixel_t    taps [9],
    input  logic                win_valid,
    input  edge_pkg::coord_x_t  win_x,
    input  edge_pkg::coord_y_t  win_y,
    pixel_stream_if.src         o
);

    edge_pkg::grad_t    row_sum [3];
    edge_pkg::mag_t     blur_sum;
    edge_pkg::mag_t     sum_q;
    logic               v_q;
    edge_pkg::coord_x_t x_q;
    edge_pkg::coord_y_t y_q;

    // horizontal pass per row, then vertical weighting
    always_comb begin
        for (int r = 0; r < 3; r++) begin
            row_sum[r] = edge_pkg::grad_t'(taps[3*r])
                       + (edge_pkg::grad_t'(taps[3*r+1]) << 1)
                       + edge_pkg::grad_t'(taps[3*r+2]);
        end
        blur_sum = edge_pkg::mag_t'(row_sum[0])
                 + (edge_pkg::mag_t'(row_sum[1]) << 1)
                 + edge_pkg::mag_t'(row_sum[2]);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            v_q     <= 1'b0;
            o.valid <= 1'b0;
        end else begin
            v_q     <= win_valid;
            o.valid <= v_q;
        end
    end

    always_ff @(posedge clk) begin
        sum_q   <= blur_sum;
        x_q     <= win_x;
        y_q     <= win_y;
        o.pixel <= sum_q[11:4];     // /16
        o.x     <= x_q;
        o.y     <= y_q;
    end

endmodule

//--- hw/sobel_edge.sv
/* sobel |gx| + |gy|, saturated to 8 bits and thresholded, 2 cycles
   output is 0xff at or above threshold, so a threshold of 0 marks every pixel */
module sobel_edge (
    input  logic                clk,
    input  logic                rst,
    input  edge_pkg::pixel_t    taps [9],
    input  logic                win_valid,
    input  edge_pkg::coord_x_t  win_x,
    input  edge_pkg::coord_y_t  win_y,
    input  edge_pkg::pixel_t    threshold,
    pixel_stream_if.src         o
);

    edge_pkg::grad_t    gx_pos, gx_neg;
    edge_pkg::grad_t    gy_pos, gy_neg;
    edge_pkg::grad_t    gx_abs, gy_abs;
    edge_pkg::mag_t     mag;
    edge_pkg::pixel_t   mag_sat;
    logic               v_q;
    edge_pkg::coord_x_t x_q;
    edge_pkg::coord_y_t y_q;

    // gx: right column minus left column
    assign gx_pos = edge_pkg::grad_t'(taps[2]) + (edge_pkg::grad_t'(taps[5]) << 1)
                  + edge_pkg::grad_t'(taps[8]);
    assign gx_neg = edge_pkg::grad_t'(taps[0]) + (edge_pkg::grad_t'(taps[3]) << 1)
                  + edge_pkg::grad_t'(taps[6]);

    // gy: oldest row minus newest row
    assign gy_pos = edge_pkg::grad_t'(taps[0]) + (edge_pkg::grad_t'(taps[1]) << 1)
                  + edge_pkg::grad_t'(taps[2]);
    assign gy_neg = edge_pkg::grad_t'(taps[6]) + (edge_pkg::grad_t'(taps[7]) << 1)
                  + edge_pkg::grad_t'(taps[8]);

    assign mag     = edge_pkg::mag_t'(gx_abs) + edge_pkg::mag_t'(gy_abs);
    assign mag_sat = (mag > 12'd255) ? 8'hff : mag[7:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            v_q     <= 1'b0;
            o.valid <= 1'b0;
        end else begin
            v_q     <= win_valid;
            o.valid <= v_q;
        end
    end

    always_ff @(posedge clk) begin
        gx_abs  <= (gx_pos >= gx_neg) ? gx_pos - gx_neg : gx_neg - gx_pos;
        gy_abs  <= (gy_pos >= gy_neg) ? gy_pos - gy_neg : gy_neg - gy_pos;
        x_q     <= win_x;
        y_q     <= win_y;
        o.pixel <= (mag_sat >= threshold) ? 8'hff : 8'h00;
        o.x     <= x_q;
        o.y     <= y_q;
    end

endmodule

//--- hw/wb_edge_regs.sv
/* wishbone classic slave, single-cycle ack one clock after the request
   writes land together with the ack; read data is valid only while ack is high */
`include "edge_consts.svh"

module wb_edge_regs (
    input  logic                clk,
    input  logic                rst,
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    input  edge_pkg::wb_addr_t  wb_adr,
    input  logic [31:0]         wb_dat_w,
    output logic [31:0]         wb_dat_r,
    output logic                wb_ack,
    input  logic                edge_seen,
    output logic                enable,
    output edge_pkg::pixel_t    threshold
);

    logic        req;
    logic [15:0] edge_count;

    assign req = wb_cyc && wb_stb && !wb_ack;   // ack drops even if stb stays

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack     <= 1'b0;
            enable     <= 1'b0;
            threshold  <= 8'h80;
            edge_count <= '0;
        end else begin
            wb_ack <= req;
            if (req && wb_we && wb_adr == `EDGE_REG_COUNT) begin
                edge_count <= '0;                   // clear beats increment
            end else if (edge_seen && edge_count != 16'hffff) begin
                edge_count <= edge_count + 16'd1;
            end
            if (req && wb_we) begin
                case (wb_adr)
                    `EDGE_REG_CTRL:   enable    <= wb_dat_w[0];
                    `EDGE_REG_THRESH: threshold <= wb_dat_w[7:0];
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        case (wb_adr)
            `EDGE_REG_CTRL:   wb_dat_r <= {31'd0, enable};
            `EDGE_REG_THRESH: wb_dat_r <= {24'd0, threshold};
            `EDGE_REG_COUNT:  wb_dat_r <= {16'd0, edge_count};
            default:          wb_dat_r <= '0;
        endcase
    end

endmodule

//--- hw/edge_detect_top.sv
/* gaussian blur then sobel edge map, 6 cycles from pixel in to edge out
   no back-pressure; clearing enable stops intake, pixels in flight still finish */
module edge_detect_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                pix_valid,
    input  edge_pkg::pixel_t    pix_data,
    input  edge_pkg::coord_x_t  pix_x,
    input  edge_pkg::coord_y_t  pix_y,
    output logic                edge_valid,
    output edge_pkg::pixel_t    edge_data,
    output edge_pkg::coord_x_t  edge_x,
    output edge_pkg::coord_y_t  edge_y,
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    input  edge_pkg::wb_addr_t  wb_adr,
    input  logic [31:0]         wb_dat_w,
    output logic [31:0]         wb_dat_r,
    output logic                wb_ack
);

    pixel_stream_if s_in ();
    pixel_stream_if s_blur ();
    pixel_stream_if s_edge ();

    edge_pkg::pixel_t   win0_taps [9];
    edge_pkg::pixel_t   win1_taps [9];
    logic               win0_valid, win1_valid;
    edge_pkg::coord_x_t win0_x, win1_x;
    edge_pkg::coord_y_t win0_y, win1_y;
    logic               enable;
    edge_pkg::pixel_t   threshold;
    logic               edge_seen;

    // intake gated by the enable bit
    assign s_in.valid = pix_valid && enable;
    assign s_in.pixel = pix_data;
    assign s_in.x     = pix_x;
    assign s_in.y     = pix_y;

    line_window_3x3 u_win0 (
        .clk(clk), .rst(rst), .s(s_in), .taps(win0_taps),
        .win_valid(win0_valid), .win_x(win0_x), .win_y(win0_y)
    );

    gauss_3x3 u_gauss (
        .clk(clk), .rst(rst), .taps(win0_taps), .win_valid(win0_valid),
        .win_x(win0_x), .win_y(win0_y), .o(s_blur)
    );

    line_window_3x3 u_win1 (
        .clk(clk), .rst(rst), .s(s_blur), .taps(win1_taps),
        .win_valid(win1_valid), .win_x(win1_x), .win_y(win1_y)
    );

    sobel_edge u_sobel (
        .clk(clk), .rst(rst), .taps(win1_taps), .win_valid(win1_valid),
        .win_x(win1_x), .win_y(win1_y), .threshold(threshold), .o(s_edge)
    );

    assign edge_seen = s_edge.valid && (s_edge.pixel == 8'hff);

    wb_edge_regs u_regs (
        .clk(clk), .rst(rst), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .edge_seen(edge_seen), .enable(enable), .threshold(threshold)
    );

    assign edge_valid = s_edge.valid;
    assign edge_data  = s_edge.pixel;
    assign edge_x     = s_edge.x;
    assign edge_y     = s_edge.y;

endmodule

//--- testbench/tb_edge_detect.sv
/* random frames of 6 lines at full line width through edge_detect_top
   expected edge map comes from a zero-padded gaussian and sobel model kept here
   outputs are sampled on the falling edge, inputs change on the rising edge */
`include "edge_consts.svh"

module tb_edge_detect;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int FRAME_H     = 6;
    localparam int FRAME_PIX   = `EDGE_LINE_W * FRAME_H;
    localparam int PIX_SLOTS   = 5 * FRAME_PIX;     // gapped frame counts twice
    localparam int BUS_CYCLES  = 16 * 4;            // 16 accesses of at most 4 cycles each
    localparam int CYCLE_LIMIT = PIX_SLOTS + BUS_CYCLES + 200;

    logic                clk = 1'b0;
    logic                rst;
    logic                pix_valid;
    edge_pkg::pixel_t    pix_data;
    edge_pkg::coord_x_t  pix_x;
    edge_pkg::coord_y_t  pix_y;
    logic                edge_valid;
    edge_pkg::pixel_t    edge_data;
    edge_pkg::coord_x_t  edge_x;
    edge_pkg::coord_y_t  edge_y;
    logic                wb_cyc;
    logic                wb_stb;
    logic                wb_we;
    edge_pkg::wb_addr_t  wb_adr;
    logic [31:0]         wb_dat_w;
    logic [31:0]         wb_dat_r;
    logic                wb_ack;

    logic [31:0] lfsr_state = 32'h85b0;
    int          img      [FRAME_H][`EDGE_LINE_W];
    int          blur     [FRAME_H][`EDGE_LINE_W];
    int          edge_map [FRAME_H][`EDGE_LINE_W];
    int          ff_count;
    logic [24:0] exp_q [$];                         // {y, x, edge value}
    int          err_count = 0;
    int          cycle_count = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    logic        lat_armed = 1'b0;
    int          first_in;
    int          first_out;
    int          test_errs;
    int          thr;
    logic [31:0] rd;

    edge_detect_top UUT (
        .clk(clk), .rst(rst), .pix_valid(pix_valid), .pix_data(pix_data),
        .pix_x(pix_x), .pix_y(pix_y), .edge_valid(edge_valid), .edge_data(edge_data),
        .edge_x(edge_x), .edge_y(edge_y), .wb_cyc(wb_cyc), .wb_stb(wb_stb),
        .wb_we(wb_we), .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r),
        .wb_ack(wb_ack)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, pipeline or bus never finished", cycle_count);
            $display(">>> FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);   // taps 32 22 2 1
    endfunction

    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = (v << 1) | int'(lfsr_state[0]);
        end
        return v;
    endfunction

    task automatic check_eq(input string name, input int seen, input int expected);
        assert (seen == expected) else begin
            $display("error at %0d ns: %s expected %0d, seen %0d", $time, name, expected, seen);
            err_count++;
        end
    endtask

    // zero above and left of the image
    function automatic int img_at(input int y, input int x);
        return (y < 0 || x < 0) ? 0 : img[y][x];
    endfunction

    function automatic int blur_at(input int y, input int x);
        return (y < 0 || x < 0) ? 0 : blur[y][x];
    endfunction

    task automatic fill_image();
        for (int y = 0; y < FRAME_H; y++) begin
            for (int x = 0; x < `EDGE_LINE_W; x++) begin
                img[y][x] = rand_bits(8);
            end
        end
    endtask

    // each result sits at the window's newest pixel with the kernel centred one up and left
    task automatic build_model(input int threshold);
        int w [3] = '{1, 2, 1};
        int acc;
        int gx;
        int gy;
        int mag;
        ff_count = 0;
        for (int y = 0; y < FRAME_H; y++) begin
            for (int x = 0; x < `EDGE_LINE_W; x++) begin
                acc = 0;
                for (int r = 0; r < 3; r++) begin
                    for (int c = 0; c < 3; c++) begin
                        acc += w[r] * w[c] * img_at(y - 2 + r, x - 2 + c);
                    end
                end
                blur[y][x] = acc / 16;
            end
        end
        for (int y = 0; y < FRAME_H; y++) begin
            for (int x = 0; x < `EDGE_LINE_W; x++) begin
                gx = 0;
                gy = 0;
                for (int k = 0; k < 3; k++) begin
                    gx += w[k] * (blur_at(y - 2 + k, x) - blur_at(y - 2 + k, x - 2));
                    gy += w[k] * (blur_at(y - 2, x - 2 + k) - blur_at(y, x - 2 + k));
                end
                mag = (gx < 0 ? -gx : gx) + (gy < 0 ? -gy : gy);
                if (mag > 255) mag = 255;
                edge_map[y][x] = (mag >= threshold) ? 255 : 0;
                if (edge_map[y][x] == 255) ff_count++;
            end
        end
    endtask

    task automatic bus_access(input logic write, input edge_pkg::wb_addr_t adr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        int waits;
        waits = 0;
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= write;
        wb_adr   <= adr;
        wb_dat_w <= wdata;
        @(negedge clk);
        while (!wb_ack && waits < 8) begin
            waits++;
            @(negedge clk);
        end
        assert (wb_ack) else begin
            $display("no wb_ack within 8 cycles for register %0d", adr);
            err_count++;
        end
        check_eq("wb_ack delay", waits, 1);
        rdata = wb_dat_r;
        @(posedge clk);             // strobe still high at this edge
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        @(negedge clk);
        check_eq("wb_ack", int'(wb_ack), 0);
    endtask

    task automatic write_reg(input edge_pkg::wb_addr_t adr, input logic [31:0] data);
        bus_access(1'b1, adr, data, rd);
    endtask

    task automatic read_check(input edge_pkg::wb_addr_t adr, input int expected,
                              input string name);
        bus_access(1'b0, adr, 32'd0, rd);
        check_eq(name, int'(rd), expected);
    endtask

    task automatic send_frame(input logic gaps, input logic expect_out);
        for (int y = 0; y < FRAME_H; y++) begin
            for (int x = 0; x < `EDGE_LINE_W; x++) begin
                if (gaps && rand_bits(2) == 3) begin
                    @(posedge clk);
                    pix_valid <= 1'b0;          // one idle slot
                end
                @(posedge clk);
                pix_valid <= 1'b1;
                pix_data  <= edge_pkg::pixel_t'(img[y][x]);
                pix_x     <= edge_pkg::coord_x_t'(x);
                pix_y     <= edge_pkg::coord_y_t'(y);
                if (expect_out) begin
                    exp_q.push_back({edge_pkg::coord_y_t'(y), edge_pkg::coord_x_t'(x),
                                     edge_pkg::pixel_t'(edge_map[y][x])});
                end
            end
        end
        @(posedge clk);
        pix_valid <= 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) @(negedge clk);
        repeat (4) @(negedge clk);      // room for a stray extra output
    endtask

    task automatic finish_test(input int num, input string name, input int errs_before);
        if (err_count == errs_before) begin
            tests_passed++;
            $display("test %0d %s: ok", num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", num, name, err_count - errs_before);
        end
    endtask

    // output monitor that also records the first in and out cycle
    always @(negedge clk) begin
        logic [24:0] e;
        if (lat_armed && pix_valid && first_in < 0) first_in = cycle_count;
        if (lat_armed && edge_valid && first_out < 0) first_out = cycle_count;
        if (edge_valid) begin
            assert (exp_q.size() > 0) else begin
                $display("edge_valid high at %0d ns with no pixel waiting for a result", $time);
                err_count++;
            end
            if (exp_q.size() > 0) begin
                e = exp_q.pop_front();
                check_eq("edge_y", int'(edge_y), int'(e[24:17]));
                check_eq("edge_x", int'(edge_x), int'(e[16:8]));
                check_eq("edge_data", int'(edge_data), int'(e[7:0]));
            end
        end
    end

    initial begin
        rst       <= 1'b1;
        pix_valid <= 1'b0;
        pix_data  <= '0;
        pix_x     <= '0;
        pix_y     <= '0;
        wb_cyc    <= 1'b0;
        wb_stb    <= 1'b0;
        wb_we     <= 1'b0;
        wb_adr    <= '0;
        wb_dat_w  <= '0;
        first_in  = -1;
        first_out = -1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);

        test_errs = err_count;
        check_eq("edge_valid", int'(edge_valid), 0);
        check_eq("wb_ack", int'(wb_ack), 0);
        read_check(`EDGE_REG_CTRL, 0, "ctrl");
        read_check(`EDGE_REG_THRESH, 'h80, "threshold");
        read_check(`EDGE_REG_COUNT, 0, "count");
        finish_test(1, "reset values", test_errs);

        test_errs = err_count;
        write_reg(`EDGE_REG_THRESH, 32'h5a);
        read_check(`EDGE_REG_THRESH, 'h5a, "threshold");
        write_reg(`EDGE_REG_CTRL, 32'h1);
        read_check(`EDGE_REG_CTRL, 1, "ctrl");
        finish_test(2, "wishbone access", test_errs);

        test_errs = err_count;
        fill_image();
        build_model('h40);
        write_reg(`EDGE_REG_THRESH, 32'h40);
        lat_armed = 1'b1;
        send_frame(1'b0, 1'b1);
        wait_drain();
        lat_armed = 1'b0;
        check_eq("first edge_valid latency", first_out - first_in, `EDGE_TOTAL_LAT);
        finish_test(3, "back-to-back frame", test_errs);

        test_errs = err_count;
        fill_image();
        thr = rand_bits(8);
        build_model(thr);
        write_reg(`EDGE_REG_THRESH, thr);
        send_frame(1'b1, 1'b1);
        wait_drain();
        finish_test(4, "frame with gaps", test_errs);

        test_errs = err_count;
        write_reg(`EDGE_REG_CTRL, 32'h0);
        fill_image();
        send_frame(1'b0, 1'b0);         // intake closed so the monitor flags any output
        repeat (20) @(negedge clk);
        write_reg(`EDGE_REG_CTRL, 32'h1);
        write_reg(`EDGE_REG_COUNT, 32'h0);
        fill_image();
        build_model('h40);
        write_reg(`EDGE_REG_THRESH, 32'h40);
        send_frame(1'b0, 1'b1);
        wait_drain();
        finish_test(5, "enable off and on", test_errs);

        test_errs = err_count;
        read_check(`EDGE_REG_COUNT, ff_count, "count");
        write_reg(`EDGE_REG_COUNT, 32'hffff);
        read_check(`EDGE_REG_COUNT, 0, "count");
        finish_test(6, "edge count", test_errs);

        $display("tests passed %0d, failed %0d, check errors %0d",
                 tests_passed, tests_failed, err_count);
        if (err_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- flist.f
+incdir+include
hw/edge_pkg.sv
hw/pixel_stream_if.sv
hw/line_window_3x3.sv
hw/gauss_3x3.sv
hw/sobel_edge.sv
hw/wb_edge_regs.sv
hw/edge_detect_top.sv
testbench/tb_edge_detect.sv

//--- Makefile
# Verilator build for the edge detection testbench
VERILATOR ?= verilator
TOP       ?= tb_edge_detect
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= >>> PASS

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$($(SIM))"; echo "$$out"; \
	echo "$$out" | grep -q -F -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
